// ==== design/kf_fixed_pkg.sv ====
/*
 * Fixed-point support for the Kalman tracker
 * Signed Q16.16 word type, constants and the multiply and divide helpers
 * shared by every stage of the filter
 */

package kf_fixed_pkg;

    // ----------------------------------------
    // Word format
    // ----------------------------------------
    localparam int FRAC_BITS  = 16;  // Q16.16
    localparam int DATA_WIDTH = 32;
    localparam int LIK_SHIFT  = 4;   // d^2 / 16 in the likelihood proxy

    typedef logic signed [DATA_WIDTH-1:0]   fp_t;       // One fixed-point word
    typedef logic signed [2*DATA_WIDTH-1:0] fp_wide_t;  // Full product / shifted dividend

    localparam fp_t FP_ONE  = fp_t'(1) <<< FRAC_BITS;  // 1.0
    localparam fp_t FP_ZERO = '0;                      // 0.0

    // ----------------------------------------
    // Arithmetic
    // ----------------------------------------

    // Full-width product, rescaled and truncated back to one word
    function automatic fp_t fp_mul(input fp_t a, input fp_t b);
        fp_wide_t prod;
        prod = fp_wide_t'(a) * fp_wide_t'(b);
        return prod[DATA_WIDTH+FRAC_BITS-1:FRAC_BITS];  // Same as >>> FRAC_BITS
    endfunction

    // Quotient truncates toward zero
    // Zero divisor is regularized to 1.0
    function automatic fp_t fp_div(input fp_t num, input fp_t den);
        fp_wide_t num_ext;
        fp_wide_t quot;
        if (den == FP_ZERO)
            return FP_ONE;
        num_ext = fp_wide_t'(num) <<< FRAC_BITS;  // Pre-scale so the result stays Q16.16
        quot    = num_ext / fp_wide_t'(den);
        return quot[DATA_WIDTH-1:0];
    endfunction

endpackage

// ==== design/kf_track_pkg.sv ====
/*
 * Tracker data types
 * State, covariance and configuration of the one-axis constant-velocity
 * filter, and the payloads passed between the predict, gain and update stages
 */

package kf_track_pkg;

    import kf_fixed_pkg::*;

    // ----------------------------------------
    // Filter state
    // ----------------------------------------
    typedef struct packed {
        fp_t pos;  // Position
        fp_t vel;  // Velocity
    } kf_state_t;

    typedef struct packed {
        fp_t p00;  // Var(pos)
        fp_t p01;
        fp_t p10;
        fp_t p11;  // Var(vel)
    } kf_cov_t;

    // Static model, held steady by the parent while running
    typedef struct packed {
        fp_t dt;     // Time step
        fp_t q_pos;  // Process noise on position
        fp_t q_vel;  // Process noise on velocity
        fp_t r;      // Measurement noise
        fp_t p0;     // Initial variance on both axes
    } kf_cfg_t;

    // ----------------------------------------
    // Stage payloads
    // ----------------------------------------
    typedef struct packed {
        logic      init;  // Init request travels with the measurement
        fp_t       z;
        kf_state_t xp;    // Predicted state
        kf_cov_t   pp;    // Predicted covariance
    } kf_pred_t;

    typedef struct packed {
        logic      init;
        fp_t       z;
        kf_state_t xp;
        kf_cov_t   pp;
        fp_t       y;      // Innovation
        fp_t       s_inv;  // 1 / (pp00 + r)
        fp_t       k0;     // Gain on position
        fp_t       k1;     // Gain on velocity
    } kf_gain_t;

    typedef struct packed {
        kf_state_t x;
        kf_cov_t   p;
        fp_t       likelihood;  // 1 / (1 + d^2/16)
    } kf_est_t;

endpackage

// ==== design/kf_predict_stage.sv ====
/*
 * Kalman tracker predict stage
 * Accepts one measurement when the loop is idle and registers the
 * state and covariance propagated over dt, plus process noise
 */

`timescale 1ns/1ps

module kf_predict_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    meas_valid,
    input  logic                    meas_init,
    input  kf_fixed_pkg::fp_t       meas_z,
    input  kf_track_pkg::kf_cfg_t   cfg,
    input  kf_track_pkg::kf_state_t cur_state,
    input  kf_track_pkg::kf_cov_t   cur_cov,
    input  logic                    loop_idle,
    output logic                    meas_ready,
    output logic                    pred_valid,
    output kf_track_pkg::kf_pred_t  pred
);

    import kf_fixed_pkg::*;
    import kf_track_pkg::*;

    logic      accept;      // Measurement handshake
    fp_t       a, b;        // Rows of F*P
    kf_state_t xp_n;
    kf_cov_t   pp_n;

    assign meas_ready = loop_idle;  // One item in the loop at a time
    assign accept     = meas_valid & meas_ready;

    // ----------------------------------------
    // F = [1 dt; 0 1], P' = F P F^T + Q
    // ----------------------------------------
    always_comb begin
        xp_n.pos = cur_state.pos + fp_mul(cfg.dt, cur_state.vel);
        xp_n.vel = cur_state.vel;                    // Constant velocity
        a        = cur_cov.p00 + fp_mul(cfg.dt, cur_cov.p10);
        b        = cur_cov.p01 + fp_mul(cfg.dt, cur_cov.p11);
        pp_n.p00 = a + fp_mul(b, cfg.dt) + cfg.q_pos;
        pp_n.p01 = b;
        pp_n.p10 = cur_cov.p10 + fp_mul(cur_cov.p11, cfg.dt);
        pp_n.p11 = cur_cov.p11 + cfg.q_vel;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pred_valid <= 1'b0;
        end else begin
            pred_valid <= accept;  // Gain stage always takes it next edge
        end
    end

    // Payload only, no reset
    always_ff @(posedge clk) begin
        if (accept) begin
            pred.init <= meas_init;
            pred.z    <= meas_z;
            pred.xp   <= xp_n;
            pred.pp   <= pp_n;
        end
    end

    // No new measurement may enter while the previous one is in flight
    a_no_accept_busy : assert property (
        @(posedge clk) disable iff (!rst_n) pred_valid |-> !(meas_valid && meas_ready));

endmodule

// ==== design/kf_gain_stage.sv ====
/*
 * Kalman tracker gain stage
 * Forms the innovation, the reciprocal of its variance and the two gains
 * for H = [1 0], and forwards them with the predicted payload
 */

`timescale 1ns/1ps

module kf_gain_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  kf_track_pkg::kf_cfg_t  cfg,
    input  logic                   pred_valid,
    input  kf_track_pkg::kf_pred_t pred,
    output logic                   gain_valid,
    output kf_track_pkg::kf_gain_t gain
);

    import kf_fixed_pkg::*;
    import kf_track_pkg::*;

    fp_t      s;       // Innovation variance, H Pp H^T + R
    kf_gain_t gain_n;

    // ----------------------------------------
    // Innovation and gain
    // ----------------------------------------
    always_comb begin
        s            = pred.pp.p00 + cfg.r;        // Scalar, so the 2x2 inverse collapses
        gain_n.init  = pred.init;
        gain_n.z     = pred.z;
        gain_n.xp    = pred.xp;
        gain_n.pp    = pred.pp;
        gain_n.y     = pred.z - pred.xp.pos;       // z - H xp
        gain_n.s_inv = fp_div(FP_ONE, s);          // Zero s regularized inside fp_div
        gain_n.k0    = fp_mul(pred.pp.p00, gain_n.s_inv);
        gain_n.k1    = fp_mul(pred.pp.p10, gain_n.s_inv);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gain_valid <= 1'b0;
        end else begin
            gain_valid <= pred_valid;  // Update stage is always free here
        end
    end

    always_ff @(posedge clk) begin
        if (pred_valid)
            gain <= gain_n;
    end

    // Only one item in the loop, so a predict result never meets a pending gain result
    a_single_item : assert property (
        @(posedge clk) disable iff (!rst_n) pred_valid |-> !gain_valid);

endmodule

// ==== design/kf_update_stage.sv ====
/*
 * Kalman tracker update stage
 * Owns the stored estimate, applies the measurement correction or the
 * init load, forms the likelihood proxy and holds the result at the
 * output until it is taken. Also reports when the loop is empty.
 */

`timescale 1ns/1ps

module kf_update_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  kf_track_pkg::kf_cfg_t   cfg,
    input  logic                    pred_valid,
    input  logic                    gain_valid,
    input  kf_track_pkg::kf_gain_t  gain,
    input  logic                    est_ready,
    output logic                    est_valid,
    output kf_track_pkg::kf_est_t   est,
    output kf_track_pkg::kf_state_t cur_state,
    output kf_track_pkg::kf_cov_t   cur_cov,
    output logic                    loop_idle
);

    import kf_fixed_pkg::*;
    import kf_track_pkg::*;

    fp_t     sy;     // s_inv * y
    fp_t     d_sq;   // Squared Mahalanobis distance
    kf_est_t est_n;  // Next estimate

    // ----------------------------------------
    // Correction, covariance and likelihood
    // ----------------------------------------
    always_comb begin
        sy   = fp_mul(gain.s_inv, gain.y);
        d_sq = fp_mul(gain.y, sy);
        if (gain.init) begin
            est_n.x.pos      = gain.z;   // Position straight from the measurement
            est_n.x.vel      = FP_ZERO;
            est_n.p.p00      = cfg.p0;
            est_n.p.p01      = FP_ZERO;
            est_n.p.p10      = FP_ZERO;
            est_n.p.p11      = cfg.p0;
            est_n.likelihood = FP_ONE;
        end else begin
            est_n.x.pos = gain.xp.pos + fp_mul(gain.k0, gain.y);
            est_n.x.vel = gain.xp.vel + fp_mul(gain.k1, gain.y);
            // P = (I - K H) Pp, H = [1 0] so only row 0 of Pp feeds the products
            est_n.p.p00 = gain.pp.p00 - fp_mul(gain.k0, gain.pp.p00);
            est_n.p.p01 = gain.pp.p01 - fp_mul(gain.k0, gain.pp.p01);
            est_n.p.p10 = gain.pp.p10 - fp_mul(gain.k1, gain.pp.p00);
            est_n.p.p11 = gain.pp.p11 - fp_mul(gain.k1, gain.pp.p01);
            est_n.likelihood = fp_div(FP_ONE, FP_ONE + (d_sq >>> LIK_SHIFT));
        end
    end

    // ----------------------------------------
    // Output register and handshake
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            est_valid <= 1'b0;
            est       <= '{x: '0, p: '0, likelihood: FP_ONE};  // Empty filter
        end else if (gain_valid) begin
            est_valid <= 1'b1;  // Output is always empty when a result arrives
            est       <= est_n;
        end else if (est_valid && est_ready) begin
            est_valid <= 1'b0;  // Taken; est keeps the filter state
        end
    end

    // Stored estimate doubles as the recursion state
    assign cur_state = est.x;
    assign cur_cov   = est.p;

    // Nothing in flight and nothing waiting at the output
    assign loop_idle = !est_valid && !gain_valid && !pred_valid;

    // Back-pressure holds the result steady
    a_est_hold : assert property (
        @(posedge clk) disable iff (!rst_n)
        (est_valid && !est_ready) |=> (est_valid && $stable(est)));

endmodule

// ==== design/kf_tracker_top.sv ====
/*
 * One-axis constant-velocity Kalman tracker
 * Predict, gain and update stages in a chain, with the stored estimate
 * fed back to the predict stage. One measurement in the loop at a time.
 */

`timescale 1ns/1ps

module kf_tracker_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  meas_valid,
    input  logic                  meas_init,
    input  kf_fixed_pkg::fp_t     meas_z,
    output logic                  meas_ready,
    input  kf_track_pkg::kf_cfg_t cfg,
    input  logic                  est_ready,
    output logic                  est_valid,
    output kf_track_pkg::kf_est_t est
);

    import kf_fixed_pkg::*;
    import kf_track_pkg::*;

    // ----------------------------------------
    // Stage chain and feedback
    // ----------------------------------------
    logic      pred_valid;
    kf_pred_t  pred;
    logic      gain_valid;
    kf_gain_t  gain;
    kf_state_t cur_state;  // Stored estimate back to predict
    kf_cov_t   cur_cov;
    logic      loop_idle;

    kf_predict_stage predict_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .meas_valid (meas_valid),
        .meas_init  (meas_init),
        .meas_z     (meas_z),
        .cfg        (cfg),
        .cur_state  (cur_state),
        .cur_cov    (cur_cov),
        .loop_idle  (loop_idle),
        .meas_ready (meas_ready),
        .pred_valid (pred_valid),
        .pred       (pred)
    );

    kf_gain_stage gain_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .pred_valid (pred_valid),
        .pred       (pred),
        .gain_valid (gain_valid),
        .gain       (gain)
    );

    kf_update_stage update_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .pred_valid (pred_valid),
        .gain_valid (gain_valid),
        .gain       (gain),
        .est_ready  (est_ready),
        .est_valid  (est_valid),
        .est        (est),
        .cur_state  (cur_state),
        .cur_cov    (cur_cov),
        .loop_idle  (loop_idle)
    );

endmodule

// ==== test/kf_model.svh ====
/*
 * Reference model of one tracker step
 * Q16.16 arithmetic built on 64-bit integers, with its own copy of the
 * filter state. Included inside the testbench module.
 */

`ifndef KF_MODEL_SVH
`define KF_MODEL_SVH

kf_state_t model_x = '0;  // Filter state after the last step
kf_cov_t   model_p = '0;

// Product rescaled by 2^16, low word kept
function automatic fp_t mul_q16(input fp_t a, input fp_t b);
    longint prod;
    prod = longint'(a) * longint'(b);
    return fp_t'(prod >>> FRAC_BITS);
endfunction

// Scaled quotient, truncating toward zero, zero divisor gives 1.0
function automatic fp_t div_q16(input fp_t num, input fp_t den);
    longint scaled;
    if (den == FP_ZERO)
        return FP_ONE;
    scaled = longint'(num) * 65536;
    return fp_t'(scaled / longint'(den));
endfunction

// Position that the next predict will produce
function automatic fp_t predicted_pos();
    return model_x.pos + mul_q16(cfg.dt, model_x.vel);
endfunction

// One full step, init or predict/gain/update; advances the model state
function automatic kf_est_t model_step(input fp_t z, input logic init);
    kf_est_t res;
    fp_t     xp_pos, xp_vel, a, b;
    fp_t     pp00, pp01, pp10, pp11;
    fp_t     y, s_inv, k0, k1, d_sq;
    if (init) begin
        res = '{x: '{pos: z, vel: FP_ZERO},
                p: '{p00: cfg.p0, p01: FP_ZERO, p10: FP_ZERO, p11: cfg.p0},
                likelihood: FP_ONE};
    end else begin
        xp_pos = model_x.pos + mul_q16(cfg.dt, model_x.vel);
        xp_vel = model_x.vel;
        a      = model_p.p00 + mul_q16(cfg.dt, model_p.p10);
        b      = model_p.p01 + mul_q16(cfg.dt, model_p.p11);
        pp00   = a + mul_q16(b, cfg.dt) + cfg.q_pos;
        pp01   = b;
        pp10   = model_p.p10 + mul_q16(model_p.p11, cfg.dt);
        pp11   = model_p.p11 + cfg.q_vel;
        y      = z - xp_pos;                   // Innovation
        s_inv  = div_q16(FP_ONE, pp00 + cfg.r);
        k0     = mul_q16(pp00, s_inv);
        k1     = mul_q16(pp10, s_inv);
        res.x.pos = xp_pos + mul_q16(k0, y);
        res.x.vel = xp_vel + mul_q16(k1, y);
        res.p.p00 = pp00 - mul_q16(k0, pp00);
        res.p.p01 = pp01 - mul_q16(k0, pp01);
        res.p.p10 = pp10 - mul_q16(k1, pp00);
        res.p.p11 = pp11 - mul_q16(k1, pp01);
        d_sq      = mul_q16(y, mul_q16(s_inv, y));
        res.likelihood = div_q16(FP_ONE, FP_ONE + (d_sq >>> LIK_SHIFT));
    end
    model_x = res.x;
    model_p = res.p;
    return res;
endfunction

`endif

// ==== test/tb_kf_tracker.sv ====
/*
 * Testbench for the Kalman tracker
 * Directed tests against a reference model of the filter step: reset state,
 * init, a noisy ramp, zero innovation and output back-pressure
 */

`timescale 1ns/1ps

module tb_kf_tracker;

    import kf_fixed_pkg::*;
    import kf_track_pkg::*;

    localparam int  CLK_PERIOD   = 40;
    localparam int  DRIVE_DELAY  = 5;     // Inputs change this long after the edge
    localparam int  RESET_CYCLES = 10;
    localparam int  MAX_CYCLES   = 2000;  // ~30 steps of up to 40 cycles, plus margin
    localparam int  STEP_LIMIT   = 40;    // Longest wait for one handshake
    localparam int  RAMP_STEPS   = 20;
    localparam fp_t Q_NOISE      = 32'sh0000_028f;  // 0.01
    localparam fp_t P0_INIT      = 32'sh000a_0000;  // 10.0
    localparam fp_t RAMP_START   = 32'sh0002_0000;  // 2.0
    localparam fp_t RAMP_VEL     = 32'sh0000_c000;  // 0.75 per step

    logic    clk;
    logic    rst_n;
    logic    meas_valid;
    logic    meas_init;
    fp_t     meas_z;
    logic    meas_ready;
    kf_cfg_t cfg;
    logic    est_ready;
    logic    est_valid;
    kf_est_t est;
    integer  seed;
    int      cycles = 0;

    `include "kf_model.svh"

    kf_tracker_top dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .meas_valid (meas_valid),
        .meas_init  (meas_init),
        .meas_z     (meas_z),
        .meas_ready (meas_ready),
        .cfg        (cfg),
        .est_ready  (est_ready),
        .est_valid  (est_valid),
        .est        (est)
    );

    // ----------------------------------------
    // Clock and run limit
    // ----------------------------------------
    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("** FAIL **");
            $fatal(1, "Run exceeded %0d cycles without finishing", MAX_CYCLES);
        end
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic next_drive();
        @(posedge clk);
        #DRIVE_DELAY;  // Outputs settled, safe to sample and drive
    endtask

    task automatic check_word(input string test, input string field,
                              input fp_t exp_v, input fp_t act_v);
        assert (act_v === exp_v) else begin
            $display("** Error: %s %s expected %h actual %h", test, field, exp_v, act_v);
            $display("** FAIL **");
            $fatal(1, "Mismatch in test %s", test);
        end
    endtask

    task automatic check_est(input string test, input kf_est_t exp_est);
        check_word(test, "pos", exp_est.x.pos, est.x.pos);
        check_word(test, "vel", exp_est.x.vel, est.x.vel);
        check_word(test, "p00", exp_est.p.p00, est.p.p00);
        check_word(test, "p01", exp_est.p.p01, est.p.p01);
        check_word(test, "p10", exp_est.p.p10, est.p.p10);
        check_word(test, "p11", exp_est.p.p11, est.p.p11);
        check_word(test, "likelihood", exp_est.likelihood, est.likelihood);
    endtask

    // Holds meas_valid until the accepting edge has passed
    task automatic send_meas(input string test, input fp_t z, input logic init);
        int waited;
        waited     = 0;
        meas_z     = z;
        meas_init  = init;
        meas_valid = 1'b1;
        while (!meas_ready) begin
            next_drive();
            waited++;
            assert (waited < STEP_LIMIT) else begin
                $display("** FAIL **");
                $fatal(1, "Test %s: meas_ready never went high", test);
            end
        end
        next_drive();  // Accepting edge
        meas_valid = 1'b0;
        meas_init  = 1'b0;
    endtask

    // Edges from acceptance to est_valid, the accepting edge counted as 1
    task automatic wait_est(input string test, output int latency);
        latency = 1;
        while (!est_valid) begin
            next_drive();
            latency++;
            assert (latency < STEP_LIMIT) else begin
                $display("** FAIL **");
                $fatal(1, "Test %s: est_valid never arrived", test);
            end
        end
    endtask

    // One measurement, checked against the model; est_ready low for hold cycles
    task automatic run_step(input string test, input fp_t z, input logic init,
                            input int hold, output int latency);
        kf_est_t exp_est;
        kf_est_t held;
        int      i;
        exp_est   = model_step(z, init);
        est_ready = (hold == 0);
        send_meas(test, z, init);
        wait_est(test, latency);
        check_est(test, exp_est);
        held = est;
        for (i = 0; i < hold; i++) begin
            next_drive();
            check_est(test, held);  // Output frozen under back-pressure
            check_word(test, "est_valid held", 1, fp_t'(est_valid));
            check_word(test, "meas_ready held", 0, fp_t'(meas_ready));
        end
        est_ready = 1'b1;
        next_drive();  // Estimate taken
        check_word(test, "est_valid after take", 0, fp_t'(est_valid));
        check_word(test, "meas_ready after take", 1, fp_t'(meas_ready));
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic check_reset_state();
        kf_est_t empty;
        empty = '{x: model_x, p: model_p, likelihood: FP_ONE};
        check_word("reset", "meas_ready", 1, fp_t'(meas_ready));
        check_word("reset", "est_valid", 0, fp_t'(est_valid));
        check_est("reset", empty);
    endtask

    task automatic load_init();
        int latency;
        run_step("init", RAMP_START, 1'b1, 0, latency);
        check_word("init", "latency", 3, fp_t'(latency));
        check_word("init", "pos is z", RAMP_START, est.x.pos);
        check_word("init", "p11 is p0", P0_INIT, est.p.p11);
    endtask

    task automatic track_ramp();
        fp_t truth;
        int  noise;
        int  k;
        int  latency;
        for (k = 1; k <= RAMP_STEPS; k++) begin
            truth = RAMP_START + k * RAMP_VEL;
            noise = $random(seed) % 32768;  // Within +/-0.5
            run_step("ramp", truth + noise, 1'b0, 0, latency);
        end
    endtask

    task automatic zero_innovation();
        fp_t exp_pos;
        fp_t exp_vel;
        int  latency;
        exp_pos = predicted_pos();
        exp_vel = model_x.vel;
        run_step("zero_innovation", exp_pos, 1'b0, 0, latency);
        check_word("zero_innovation", "pos is prediction", exp_pos, est.x.pos);
        check_word("zero_innovation", "vel is prediction", exp_vel, est.x.vel);
        check_word("zero_innovation", "likelihood", FP_ONE, est.likelihood);
    endtask

    task automatic hold_output();
        int hold;
        int latency;
        hold = 1 + (($random(seed) & 32'h7fff_ffff) % 15);  // 1 to 15 cycles
        run_step("backpressure", predicted_pos() + 32'sh0000_4000, 1'b0, hold, latency);
        run_step("after_backpressure", predicted_pos() - 32'sh0000_2000, 1'b0, 0, latency);
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        seed       = 32'hb16ad7d7;
        rst_n      = 1'b0;
        meas_valid = 1'b0;
        meas_init  = 1'b0;
        meas_z     = FP_ZERO;
        est_ready  = 1'b1;
        cfg        = '{dt: FP_ONE, q_pos: Q_NOISE, q_vel: Q_NOISE, r: FP_ONE, p0: P0_INIT};
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        check_reset_state();
        load_init();
        track_ramp();
        zero_innovation();
        hold_output();
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== kalman_tracker.f ====
+incdir+test
design/kf_fixed_pkg.sv
design/kf_track_pkg.sv
design/kf_predict_stage.sv
design/kf_gain_stage.sv
design/kf_update_stage.sv
design/kf_tracker_top.sv
test/tb_kf_tracker.sv

// ==== Makefile ====
# Verilator build and run of the Kalman tracker testbench

VERILATOR ?= verilator
TOP       ?= tb_kf_tracker
FILELIST  ?= kalman_tracker.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= ** PASS **

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell grep -v '^+' $(FILELIST)) test/kf_model.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
